/* source/gps_demod_pkg.sv */
// GPS L1 C/A tracking channel shared definitions
// Register op bits, code constants, LO tables and the write data layout

package gps_demod_pkg;

    ////////////////////////////////////////////////////////////////////
    // Op word bit positions

    // One-hot select of the register a CPU write updates
    localparam int op_set_sat    = 0;
    localparam int op_set_pause  = 1;
    localparam int op_set_lo_nco = 2;
    localparam int op_set_cg_nco = 3;

    ////////////////////////////////////////////////////////////////////
    // C/A code

    // Chips per code period
    localparam int CODE_LEN  = 1023;
    // Chip counter width
    localparam int CHIP_BITS = 10;

    ////////////////////////////////////////////////////////////////////
    // Quadrature LO

    // Indexed by carrier phase bits 31:30
    // Cosine leads sine by a quarter cycle
    localparam logic [3:0] lo_sin_tab = 4'b1100;
    localparam logic [3:0] lo_cos_tab = 4'b0110;

    ////////////////////////////////////////////////////////////////////
    // Register write data

    // Satellite select word
    // With g2_init clear the G2 field is a tap mask, bit n-1 for stage n
    typedef struct packed {
        logic [19:0] pad;
        logic        reserved;
        logic        g2_init;
        logic [9:0]  g2_state;
    } sat_sel_t;

    // Same write word seen as an NCO rate or a satellite select
    typedef union packed {
        logic [31:0] rate;
        sat_sel_t    sat;
    } reg_data_u;

endpackage

/* source/epl_if.sv */
// Early/prompt/late code bus
// Carries the three code replicas and the epoch strobe from the
// code timing block into the correlator

`timescale 1ns/1ps

interface epl_if;

    // Current chip straight from the Gold code generator
    logic code_e;
    // Half a chip behind early
    logic code_p;
    // One chip behind early
    logic code_l;
    // One cycle when the prompt chip index is 0
    logic epoch;

    modport code_src (
        output code_e,
        output code_p,
        output code_l,
        output epoch
    );

    modport code_dst (
        input code_e,
        input code_p,
        input code_l,
        input epoch
    );

endinterface

/* source/iq_if.sv */
// Integrate-and-dump result bus
// Six correlator sums plus the dump strobe, correlator to serializer

`timescale 1ns/1ps

interface iq_if #(
    parameter int INTEG_BITS = 18
);

    // Sums as they stand before the clear
    logic [INTEG_BITS-1:0] ie;
    logic [INTEG_BITS-1:0] qe;
    logic [INTEG_BITS-1:0] ip;
    logic [INTEG_BITS-1:0] qp;
    logic [INTEG_BITS-1:0] il;
    logic [INTEG_BITS-1:0] ql;
    // Epoch delayed one clock
    logic                  dump;

    modport acc_src (
        output ie, qe, ip, qp, il, ql,
        output dump
    );

    modport acc_dst (
        input ie, qe, ip, qp, il, ql,
        input dump
    );

endinterface

/* source/chan_ctrl_regs.sv */
// Channel control registers
// Decodes CPU writes into satellite select, code and carrier NCO rates,
// and holds the code generator pause/resume state

`timescale 1ns/1ps

module chan_ctrl_regs import gps_demod_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_reg,
    input  logic [15:0] op,
    input  logic [31:0] tos,
    input  logic        cg_resume,
    output logic        g2_init,
    output logic [9:0]  g2_state,
    output logic [31:0] cg_rate,
    output logic [31:0] lo_rate,
    output logic        cg_en
);

    // One write word, two readings
    reg_data_u wr_data;

    assign wr_data = tos;

    // Every register whose op bit is set takes the word
    always_ff @(posedge clk) begin
        if (rst) begin
            g2_init  <= 1'b0;
            g2_state <= '0;
            cg_rate  <= '0;
            lo_rate  <= '0;
        end else if (wr_reg) begin
            if (op[op_set_sat]) begin
                g2_init  <= wr_data.sat.g2_init;
                g2_state <= wr_data.sat.g2_state;
            end
            if (op[op_set_lo_nco])
                lo_rate <= wr_data.rate;
            if (op[op_set_cg_nco])
                cg_rate <= wr_data.rate;
        end
    end

    // Pause freezes the code NCO until the CPU strobes resume
    always_ff @(posedge clk) begin
        if (rst)
            cg_en <= 1'b0;
        else if (wr_reg && op[op_set_pause])
            cg_en <= 1'b0;
        else if (!cg_en && cg_resume)
            cg_en <= 1'b1;
    end

endmodule

/* source/ca_code_gen.sv */
// C/A Gold code generator
// Two ten-stage LFSRs, G1 and G2, stepped once per chip.
// G2 either starts from a loaded state or is tapped by a phase mask.

`timescale 1ns/1ps

module ca_code_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       g2_init,
    input  logic [9:0] g2_state,
    input  logic       advance,
    output logic       chip
);

    // Stage n lives in bit n-1
    logic [9:0] g1;
    logic [9:0] g2;
    logic [9:0] g1_next;
    logic [9:0] g2_next;
    logic [9:0] g2_start;
    logic       g1_fb;
    logic       g2_fb;
    logic       g2_out;

    ////////////////////////////////////////////////////////////////////
    // Feedback

    // G1 = 1 + x^3 + x^10
    assign g1_fb = g1[2] ^ g1[9];

    // G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
    assign g2_fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];

    assign g1_next = {g1[8:0], g1_fb};
    assign g2_next = {g2[8:0], g2_fb};

    // Explicit start state, or all ones for the tap mask method
    assign g2_start = g2_init ? g2_state : '1;

    ////////////////////////////////////////////////////////////////////
    // Output

    // Phase taps act as a delayed G2, loaded state reads stage 10
    assign g2_out = g2_init ? g2[9] : ^(g2 & g2_state);
    assign chip   = g1[9] ^ g2_out;

    ////////////////////////////////////////////////////////////////////
    // Registers

    // G1 back at all ones marks the end of the code period
    always_ff @(posedge clk) begin
        if (rst) begin
            g1 <= '1;
            g2 <= g2_start;
        end else if (advance) begin
            if (g1_next == '1) begin
                g1 <= '1;
                g2 <= g2_start;
            end else begin
                g1 <= g1_next;
                g2 <= g2_next;
            end
        end
    end

endmodule

/* source/code_nco.sv */
// Code timing
// 32-bit code NCO with quarter, half and full chip carries, chip counter,
// early/prompt/late latching, epoch strobe and the code-phase replica

`timescale 1ns/1ps

module code_nco import gps_demod_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] cg_rate,
    input  logic        cg_en,
    input  logic        g2_init,
    input  logic [9:0]  g2_state,
    epl_if.code_src     epl,
    output logic [15:0] replica
);

    logic [31:0]          phase;
    logic [31:0]          phase_next;
    logic [30:0]          sum_lo;
    logic [1:0]           sum_30;
    logic [1:0]           sum_31;
    logic                 quarter_chip;
    logic                 half_chip;
    logic                 full_chip;
    logic                 half_chip_en;
    logic                 full_chip_en;
    logic [CHIP_BITS-1:0] chip_cnt;
    logic [CHIP_BITS-1:0] chip_idx;
    logic                 code_e;
    logic                 code_p;
    logic                 code_l;
    logic                 epoch;

    ////////////////////////////////////////////////////////////////////
    // Phase accumulator split at bits 29, 30 and 31

    assign sum_lo       = {1'b0, phase[29:0]} + {1'b0, cg_rate[29:0]};
    assign quarter_chip = sum_lo[30];

    assign sum_30    = {1'b0, phase[30]} + {1'b0, cg_rate[30]} + {1'b0, quarter_chip};
    assign half_chip = sum_30[1];

    assign sum_31    = {1'b0, phase[31]} + {1'b0, cg_rate[31]} + {1'b0, half_chip};
    assign full_chip = sum_31[1];

    assign phase_next = {sum_31[0], sum_30[0], sum_lo[29:0]};

    // A frozen accumulator produces no chip events
    assign half_chip_en = half_chip & cg_en;
    assign full_chip_en = full_chip & cg_en;

    always_ff @(posedge clk) begin
        if (rst)
            phase <= '0;
        else if (cg_en)
            phase <= phase_next;
    end

    ////////////////////////////////////////////////////////////////////
    // Gold code, steps with the chip counter

    ca_code_gen u_ca_code_gen (
        .clk      (clk),
        .rst      (rst),
        .g2_init  (g2_init),
        .g2_state (g2_state),
        .advance  (full_chip_en),
        .chip     (code_e)
    );

    ////////////////////////////////////////////////////////////////////
    // Chip count and E/P/L latching

    always_ff @(posedge clk) begin
        if (rst) begin
            chip_cnt <= '0;
            chip_idx <= '0;
            code_p   <= 1'b0;
            code_l   <= 1'b0;
            epoch    <= 1'b0;
        end else begin
            if (full_chip_en)
                chip_cnt <= (chip_cnt == CHIP_BITS'(CODE_LEN - 1)) ? '0 : chip_cnt + 1'b1;

            epoch <= 1'b0;
            if (half_chip_en) begin
                if (full_chip_en) begin
                    // Chip boundary, late follows prompt
                    code_l <= code_p;
                end else begin
                    // Mid chip, prompt follows early
                    code_p   <= code_e;
                    chip_idx <= chip_cnt;
                    epoch    <= (chip_cnt == '0);
                end
            end
        end
    end

    assign epl.code_e = code_e;
    assign epl.code_p = code_p;
    assign epl.code_l = code_l;
    assign epl.epoch  = epoch;

    // Half-chip flag, fine phase and prompt chip index
    assign replica = {~phase[31], phase[30:26], chip_idx};

endmodule

/* source/carrier_correlator.sv */
// Carrier NCO and correlator bank
// One-bit quadrature LO mixing of the IF sample against early, prompt
// and late code, followed by six integrate-and-dump accumulators

`timescale 1ns/1ps

module carrier_correlator import gps_demod_pkg::*; #(
    parameter int INTEG_BITS = 18
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,
    input  logic [31:0] lo_rate,
    epl_if.code_dst     epl,
    iq_if.acc_src       iq
);

    logic [31:0]           lo_phase;
    logic                  lo_i;
    logic                  lo_q;
    // Mixer bits in the order ie, qe, ip, qp, il, ql
    logic [5:0]            mix;
    logic [INTEG_BITS-1:0] acc [6];
    logic                  dump;
    logic                  half_cnt;
    logic                  half_bit;

    ////////////////////////////////////////////////////////////////////
    // Carrier NCO, free running

    always_ff @(posedge clk) begin
        if (rst)
            lo_phase <= '0;
        else
            lo_phase <= lo_phase + lo_rate;
    end

    assign lo_i = lo_sin_tab[lo_phase[31:30]];
    assign lo_q = lo_cos_tab[lo_phase[31:30]];

    ////////////////////////////////////////////////////////////////////
    // Mixers

    // XOR is one-bit multiply, one register stage
    always_ff @(posedge clk) begin
        mix[0] <= sample ^ epl.code_e ^ lo_i;
        mix[1] <= sample ^ epl.code_e ^ lo_q;
        mix[2] <= sample ^ epl.code_p ^ lo_i;
        mix[3] <= sample ^ epl.code_p ^ lo_q;
        mix[4] <= sample ^ epl.code_l ^ lo_i;
        mix[5] <= sample ^ epl.code_l ^ lo_q;
    end

    ////////////////////////////////////////////////////////////////////
    // Integrate and dump

    // Dump lines up with the first mixed term of the new epoch
    always_ff @(posedge clk) begin
        if (rst)
            dump <= 1'b0;
        else
            dump <= epl.epoch;
    end

    // Alternating bit adds one every second sample
    // Zero on the dump cycle
    assign half_bit = dump ? 1'b0 : half_cnt;

    always_ff @(posedge clk) begin
        if (rst)
            half_cnt <= 1'b0;
        else
            half_cnt <= ~half_bit;
    end

    // Each term is half_bit minus the mixed bit
    always_ff @(posedge clk) begin
        for (int k = 0; k < 6; k++) begin
            if (rst)
                acc[k] <= '0;
            else
                acc[k] <= (dump ? '0 : acc[k]) + {INTEG_BITS{mix[k]}} +
                          INTEG_BITS'(half_bit);
        end
    end

    assign iq.ie   = acc[0];
    assign iq.qe   = acc[1];
    assign iq.ip   = acc[2];
    assign iq.qp   = acc[3];
    assign iq.il   = acc[4];
    assign iq.ql   = acc[5];
    assign iq.dump = dump;

endmodule

/* source/iq_serializer.sv */
// IQ serializer
// Snapshots the six correlator sums at dump and shifts them out MSB
// first, one bit per CPU shift pulse

`timescale 1ns/1ps

module iq_serializer #(
    parameter int INTEG_BITS = 18
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   shift,
    iq_if.acc_dst  iq,
    output logic   sout
);

    localparam int ser_bits = 6 * INTEG_BITS;

    logic [ser_bits-1:0] ser_iq;

    // Prompt pair first, then early, then late
    // A fresh dump overwrites whatever has not been shifted yet
    always_ff @(posedge clk) begin
        if (rst)
            ser_iq <= '0;
        else if (iq.dump)
            ser_iq <= {iq.ip, iq.qp, iq.ie, iq.qe, iq.il, iq.ql};
        else if (shift)
            ser_iq <= ser_iq << 1;
    end

    assign sout = ser_iq[ser_bits-1];

endmodule

/* source/gps_demod.sv */
// GPS L1 C/A tracking channel, top level
// CPU register decode, code timing, carrier correlator and serial
// readout of the six integrate-and-dump sums

`timescale 1ns/1ps

module gps_demod #(
    parameter int INTEG_BITS = 18
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,
    input  logic        cg_resume,
    input  logic        wr_reg,
    input  logic [15:0] op,
    input  logic [31:0] tos,
    input  logic        shift,
    output logic        sout,
    output logic        ms0,
    output logic [15:0] replica
);

    logic        g2_init;
    logic [9:0]  g2_state;
    logic [31:0] cg_rate;
    logic [31:0] lo_rate;
    logic        cg_en;

    epl_if                               epl_bus ();
    iq_if #(.INTEG_BITS(INTEG_BITS))     iq_bus ();

    ////////////////////////////////////////////////////////////////////
    // Control

    chan_ctrl_regs u_chan_ctrl_regs (
        .clk       (clk),
        .rst       (rst),
        .wr_reg    (wr_reg),
        .op        (op),
        .tos       (tos),
        .cg_resume (cg_resume),
        .g2_init   (g2_init),
        .g2_state  (g2_state),
        .cg_rate   (cg_rate),
        .lo_rate   (lo_rate),
        .cg_en     (cg_en)
    );

    ////////////////////////////////////////////////////////////////////
    // Code timing, correlation, readout

    code_nco u_code_nco (
        .clk      (clk),
        .rst      (rst),
        .cg_rate  (cg_rate),
        .cg_en    (cg_en),
        .g2_init  (g2_init),
        .g2_state (g2_state),
        .epl      (epl_bus.code_src),
        .replica  (replica)
    );

    carrier_correlator #(.INTEG_BITS(INTEG_BITS)) u_carrier_correlator (
        .clk     (clk),
        .rst     (rst),
        .sample  (sample),
        .lo_rate (lo_rate),
        .epl     (epl_bus.code_dst),
        .iq      (iq_bus.acc_src)
    );

    iq_serializer #(.INTEG_BITS(INTEG_BITS)) u_iq_serializer (
        .clk   (clk),
        .rst   (rst),
        .shift (shift),
        .iq    (iq_bus.acc_dst),
        .sout  (sout)
    );

    // Epoch straight out to the CPU
    assign ms0 = epl_bus.epoch;

endmodule

/* test/tb_gps_demod.sv */
// Testbench for the GPS L1 C/A tracking channel
// Reference PRN 1 code, code timing, carrier NCO and dump model,
// checked against ms0, replica and the serial sums

`timescale 1ns/1ps

module tb_gps_demod import gps_demod_pkg::*; ();

    localparam int INTEG_BITS   = 18;
    localparam int SER_BITS     = 6 * INTEG_BITS;
    localparam int EPOCH_CYCLES = 4 * CODE_LEN;
    localparam int PAUSE_CYCLES = 37;
    // Twice six epoch periods plus six readouts
    localparam int LIMIT_CYCLES = 2 * (6 * EPOCH_CYCLES + 6 * SER_BITS);

    logic        clk = 1'b0;
    logic        rst;
    logic        sample;
    logic        cg_resume;
    logic        wr_reg;
    logic [15:0] op;
    logic [31:0] tos;
    logic        shift;
    logic        sout;
    logic        ms0;
    logic [15:0] replica;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          cyc = 0;
    logic [31:0] rng = 32'ha2e7;
    logic        rand_on = 1'b0;
    logic        chk_sout = 1'b0;
    logic        exp_bit = 1'b0;
    logic        code_tab [CODE_LEN];
    int          code_ones;

    // Reference model state
    logic        m_en;
    logic [1:0]  m_q;
    int          m_cnt;
    int          m_idx;
    logic        m_p;
    logic        m_l;
    logic        m_epoch;
    logic        m_dump;
    logic [31:0] m_lo_rate;
    logic [31:0] m_lo_ph;
    logic [5:0]  m_mix;
    int          m_n;
    int          m_ones [6];
    logic [SER_BITS-1:0] m_snap;

    gps_demod #(.INTEG_BITS(INTEG_BITS)) u_gps_demod (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .cg_resume (cg_resume),
        .wr_reg    (wr_reg),
        .op        (op),
        .tos       (tos),
        .shift     (shift),
        .sout      (sout),
        .ms0       (ms0),
        .replica   (replica)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH %0t: %s", $time, msg);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model

    // PRN 1 uses G2 phase taps at stages 2 and 6
    task automatic build_prn1_code();
        logic [10:1] g1;
        logic [10:1] g2;
        logic        f1;
        logic        f2;
        g1 = '1;
        g2 = '1;
        code_ones = 0;
        for (int k = 0; k < CODE_LEN; k++) begin
            code_tab[k] = g1[10] ^ g2[2] ^ g2[6];
            code_ones += code_tab[k];
            f1 = g1[3] ^ g1[10];
            f2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
            g1 = {g1[9:1], f1};
            g2 = {g2[9:1], f2};
        end
    endtask

    always @(posedge clk) begin : ref_model
        logic                  e;
        logic                  li;
        logic                  lq;
        logic [INTEG_BITS-1:0] s [6];
        e  = code_tab[m_cnt];
        li = lo_sin_tab[m_lo_ph[31:30]];
        lq = lo_cos_tab[m_lo_ph[31:30]];
        if (rst) begin
            m_en      <= 1'b0;
            m_q       <= '0;
            m_cnt     <= 0;
            m_idx     <= 0;
            m_p       <= 1'b0;
            m_l       <= 1'b0;
            m_epoch   <= 1'b0;
            m_dump    <= 1'b0;
            m_lo_rate <= '0;
            m_lo_ph   <= '0;
            m_n       <= 0;
        end else begin
            if (wr_reg && op[op_set_pause])
                m_en <= 1'b0;
            else if (!m_en && cg_resume)
                m_en <= 1'b1;
            if (wr_reg && op[op_set_lo_nco])
                m_lo_rate <= tos;
            m_epoch <= 1'b0;
            // Quarter chip steps with mid chip at 1 to 2 and chip edge at 3 to 0
            if (m_en) begin
                m_q <= m_q + 1'b1;
                if (m_q == 2'd1) begin
                    m_p     <= e;
                    m_idx   <= m_cnt;
                    m_epoch <= (m_cnt == 0);
                end
                if (m_q == 2'd3) begin
                    m_l   <= m_p;
                    m_cnt <= (m_cnt == CODE_LEN - 1) ? 0 : m_cnt + 1;
                end
            end
            m_lo_ph <= m_lo_ph + m_lo_rate;
            m_mix   <= {sample ^ m_l ^ lq, sample ^ m_l ^ li, sample ^ m_p ^ lq,
                        sample ^ m_p ^ li, sample ^ e ^ lq, sample ^ e ^ li};
            m_dump  <= m_epoch;
            // Sum is floor(n/2) minus the mixed ones since the last dump
            for (int k = 0; k < 6; k++)
                s[k] = INTEG_BITS'(m_n / 2 - m_ones[k]);
            if (m_dump) begin
                m_snap <= {s[2], s[3], s[0], s[1], s[4], s[5]};
                m_n    <= 1;
                for (int k = 0; k < 6; k++)
                    m_ones[k] <= m_mix[k];
            end else begin
                m_n <= m_n + 1;
                for (int k = 0; k < 6; k++)
                    m_ones[k] <= m_ones[k] + m_mix[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Assertions

    a_epoch_one_cycle: assert property (@(posedge clk) disable iff (rst) ms0 |=> !ms0)
        else report_mismatch("ms0 high for more than one cycle");

    a_epoch_timing: assert property (@(posedge clk) disable iff (rst) ms0 == m_epoch)
        else report_mismatch("ms0 differs from the code timing model");

    // Code rate stays at a quarter chip per clock
    // Phase bits 31:30 follow m_q and bits 29:26 stay zero
    a_replica_chip: assert property (@(posedge clk) disable iff (rst)
        replica == {~m_q[1], m_q[0], 4'b0000, 10'(m_idx)})
        else report_mismatch("replica differs from the code phase model");

    a_serial_bit: assert property (@(posedge clk) disable iff (rst) chk_sout |-> sout == exp_bit)
        else report_mismatch("sout bit differs from the model sums");

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Random IF samples one per clock
    always @(posedge clk) begin
        if (rand_on) begin
            #1;
            rng    = xorshift32(rng);
            sample = rng[0];
        end
    end

    task automatic write_reg(input int op_bit, input logic [31:0] data);
        wr_reg = 1'b1;
        op     = 16'(1 << op_bit);
        tos    = data;
        @(posedge clk);
        #1;
        wr_reg = 1'b0;
        op     = '0;
    endtask

    task automatic pulse_resume();
        cg_resume = 1'b1;
        @(posedge clk);
        #1;
        cg_resume = 1'b0;
    endtask

    // Returns the cycle of the next ms0 pulse
    task automatic wait_epoch(output int at);
        int t;
        t = 0;
        @(posedge clk);
        #1;
        while (ms0 !== 1'b1 && t < EPOCH_CYCLES + 2 * PAUSE_CYCLES) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (ms0 !== 1'b1) begin
            $display("ms0 did not pulse within one code period");
            errors++;
        end
        at = cyc;
    endtask

    // Shift out the snapshot taken at the dump after the next epoch
    task automatic read_sums(output logic [SER_BITS-1:0] got, output int at);
        wait_epoch(at);
        repeat (2) @(posedge clk);
        #1;
        chk_sout = 1'b1;
        for (int b = SER_BITS - 1; b >= 0; b--) begin
            got[b]  = sout;
            exp_bit = m_snap[b];
            shift   = 1'b1;
            @(posedge clk);
            #1;
        end
        shift    = 1'b0;
        chk_sout = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name, input int err_start);
        tests_run++;
        if (errors != err_start)
            tests_bad++;
        $display("test %0d %s: %s", num, name, (errors == err_start) ? "ok" : "errors");
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout, the run did not complete in time");
        $display("tests failed");
        $finish;
    end

    initial begin : main
        logic [SER_BITS-1:0] got;
        logic [INTEG_BITS-1:0] exp_sum;
        int e1;
        int e2;
        int err0;
        int prev;
        int last;
        int changes;
        rst       = 1'b1;
        sample    = 1'b0;
        cg_resume = 1'b0;
        wr_reg    = 1'b0;
        op        = '0;
        tos       = '0;
        shift     = 1'b0;
        build_prn1_code();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Code NCO idle after reset
        // Zero phase and chip count read as 16'h8000 through the inverted top bit
        err0 = errors;
        repeat (200) begin
            @(posedge clk);
            #1;
            assert (ms0 == 1'b0 && replica == 16'h8000)
                else report_mismatch("code timing moved while disabled");
        end
        finish_test(1, "idle after reset", err0);

        // PRN 1 at four cycles per chip
        err0 = errors;
        write_reg(op_set_sat, 32'h0000_0022);
        write_reg(op_set_cg_nco, 32'h4000_0000);
        write_reg(op_set_lo_nco, 32'h0);
        pulse_resume();
        wait_epoch(e1);
        wait_epoch(e2);
        assert (e2 - e1 == EPOCH_CYCLES)
            else report_mismatch($sformatf("epoch period %0d cycles", e2 - e1));
        finish_test(2, "epoch period", err0);

        // Chip index steps by one every 4 cycles and wraps
        err0 = errors;
        prev = replica[9:0];
        last = cyc;
        changes = 0;
        while (changes < CODE_LEN + 80) begin
            @(posedge clk);
            #1;
            if (replica[9:0] != prev) begin
                assert (replica[9:0] == (prev + 1) % CODE_LEN && cyc - last == 4)
                    else report_mismatch($sformatf("chip index %0d after %0d",
                        replica[9:0], prev));
                prev = replica[9:0];
                last = cyc;
                changes++;
            end
        end
        finish_test(3, "replica chip index", err0);

        // Zero sample and LO leave the code bit as the mixed bit
        // Every chip is held for four samples in a period
        err0 = errors;
        read_sums(got, e1);
        exp_sum = INTEG_BITS'(EPOCH_CYCLES / 2 - 4 * code_ones);
        for (int k = 0; k < 6; k++) begin
            assert (got[k*INTEG_BITS +: INTEG_BITS] == exp_sum)
                else report_mismatch($sformatf("sum %0d is %h, expected %h", k,
                    got[k*INTEG_BITS +: INTEG_BITS], exp_sum));
        end
        for (int k = 0; k < 6; k += 2) begin
            assert (got[k*INTEG_BITS +: INTEG_BITS] == got[(k+1)*INTEG_BITS +: INTEG_BITS])
                else report_mismatch("I and Q sums differ with a zero LO");
        end
        finish_test(4, "code-only sums", err0);

        // Random IF and carrier
        err0 = errors;
        rng = xorshift32(rng);
        write_reg(op_set_lo_nco, rng);
        rand_on = 1'b1;
        read_sums(got, e1);
        read_sums(got, e1);
        finish_test(5, "random IF sums", err0);

        // Pause shifts the next epoch by the paused cycles
        err0 = errors;
        write_reg(op_set_pause, 32'h0);
        repeat (PAUSE_CYCLES - 1) @(posedge clk);
        #1;
        pulse_resume();
        wait_epoch(e2);
        assert (e2 - e1 == EPOCH_CYCLES + PAUSE_CYCLES)
            else report_mismatch($sformatf("paused period %0d cycles", e2 - e1));
        finish_test(6, "pause and resume", err0);

        $display("%0d tests run, %0d with errors, %0d errors in total",
            tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* gps_demod.f */
source/gps_demod_pkg.sv
source/epl_if.sv
source/iq_if.sv
source/chan_ctrl_regs.sv
source/ca_code_gen.sv
source/code_nco.sv
source/carrier_correlator.sv
source/iq_serializer.sv
source/gps_demod.sv
test/tb_gps_demod.sv
